// ==== common/pci_pkg.sv ====
`default_nettype none

package pci_pkg;

    // only the two memory commands get a response
    typedef enum logic [3:0] {
        PCI_MEM_READ  = 4'b0110,
        PCI_MEM_WRITE = 4'b0111
    } pci_cmd_t;

    // sampled pins with active-low strobes
    typedef struct packed {
        logic        frame_n;
        logic        irdy_n;
        logic [31:0] ad;
        logic [3:0]  cbe_n;
    } pci_in_t;

    // driven pins with their output enables
    typedef struct packed {
        logic        devsel_n;
        logic        trdy_n;
        logic [31:0] ad;
        logic        devsel_oe;
        logic        trdy_oe;
        logic        ad_oe;
    } pci_out_t;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        WAIT_IRDY,
        WB_CYCLE,
        DATA,
        TURN
    } tgt_state_t;

endpackage

`default_nettype wire

// ==== common/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // bus widths
    localparam int WB_DW = 32;
    localparam int WB_SW = 4;

    // master to slave
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [31:0]      adr;
        logic [WB_SW-1:0] sel;
        logic [WB_DW-1:0] dat;
    } wb_req_t;

    // slave to master without rty and err
    typedef struct packed {
        logic             ack;
        logic [WB_DW-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== pci_target/pci_target_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pci_target_fsm
    import wb_pkg::*, pci_pkg::*;
#(
    parameter logic [15:0] BAR_BASE = 16'h8000
)
(
    input  wire          pci_clk_pad_i,
    input  wire          pci_rst_pad_i,
    input  wire pci_in_t pci_i,
    output pci_out_t     pci_o,
    output wb_req_t      wbm_req_o,
    input  wire wb_rsp_t wbm_rsp_i
);

    tgt_state_t state_q;
    tgt_state_t state_d;

    logic [31:0]      adr_q;
    pci_cmd_t         cmd_q;
    logic [WB_DW-1:0] wdata_q;
    logic [WB_SW-1:0] sel_q;
    logic [WB_DW-1:0] rdata_q;

    logic mem_cmd;
    logic hit;
    logic is_read;
    logic data_take;
    logic claim;

    // window and command decode from the latched address phase
    assign mem_cmd = (cmd_q == PCI_MEM_READ) || (cmd_q == PCI_MEM_WRITE);
    assign hit     = mem_cmd && (adr_q[31:16] == BAR_BASE);
    assign is_read = (cmd_q == PCI_MEM_READ);

    // irdy may already be low while devsel is first driven
    assign data_take = ((state_q == DECODE && hit) || state_q == WAIT_IRDY) && !pci_i.irdy_n;

    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            IDLE:
            begin
                if (!pci_i.frame_n)
                    state_d = DECODE;
            end
            DECODE:
            begin
                if (!hit)
                    state_d = IDLE;
                else if (data_take)
                    state_d = WB_CYCLE;
                else
                    state_d = WAIT_IRDY;
            end
            WAIT_IRDY:
            begin
                if (data_take)
                    state_d = WB_CYCLE;
            end
            WB_CYCLE:
            begin
                if (wbm_rsp_i.ack)
                    state_d = DATA;
            end
            DATA:
                state_d = TURN;
            TURN:
                state_d = IDLE;
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge pci_clk_pad_i or negedge pci_rst_pad_i)
    begin
        if (!pci_rst_pad_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge pci_clk_pad_i)
    begin
        // address phase
        if (state_q == IDLE && !pci_i.frame_n)
        begin
            adr_q <= pci_i.ad;
            cmd_q <= pci_cmd_t'(pci_i.cbe_n);
        end
        if (data_take)
        begin
            wdata_q <= pci_i.ad;
            sel_q   <= ~pci_i.cbe_n;
        end
        if (state_q == WB_CYCLE && wbm_rsp_i.ack)
            rdata_q <= wbm_rsp_i.dat;
    end

    assign claim = (state_q == DECODE && hit) || state_q == WAIT_IRDY ||
                   state_q == WB_CYCLE || state_q == DATA;

    // TURN drives both strobes high once before release
    always_comb
    begin
        pci_o.devsel_n  = !claim;
        pci_o.devsel_oe = claim || state_q == TURN;
        pci_o.trdy_n    = (state_q != DATA);
        pci_o.trdy_oe   = claim || state_q == TURN;
        pci_o.ad        = rdata_q;
        pci_o.ad_oe     = (state_q == DATA) && is_read;
    end

    always_comb
    begin
        wbm_req_o.cyc = (state_q == WB_CYCLE);
        wbm_req_o.stb = (state_q == WB_CYCLE);
        wbm_req_o.we  = !is_read;
        wbm_req_o.adr = adr_q;
        wbm_req_o.sel = sel_q;
        wbm_req_o.dat = wdata_q;
    end

endmodule

`default_nettype wire

// ==== pci_test.f ====
common/wb_pkg.sv
common/pci_pkg.sv
pci_target/pci_target_fsm.sv
src/wb_cyc_arbiter.sv
src/wb_test_master.sv
src/wb_sram_slave.sv
src/pci_test_top.sv
verification/pci_test_sva.sv
verification/pci_test_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f pci_test.f --top-module pci_test_tb \
    -Mdir obj_dir -o pci_test_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/pci_test_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== src/pci_test_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pci_test_top
    import wb_pkg::*, pci_pkg::*;
#(
    parameter logic [15:0] BAR_BASE  = 16'h8000,
    parameter int          MEM_WORDS = 64
)
(
    input  wire              pci_clk_pad_i,
    input  wire              pci_rst_pad_i,
    input  wire pci_in_t     pci_i,
    output pci_out_t         pci_o,
    input  wire              start_i,
    input  wire wb_req_t     host_cmd_i,
    output logic             done_o,
    output logic [WB_DW-1:0] rdata_o
);

    wb_req_t pci_req;
    wb_rsp_t pci_rsp;
    wb_req_t host_req;
    wb_rsp_t host_rsp;
    wb_req_t slv_req;
    wb_rsp_t slv_rsp;

    pci_target_fsm #(
        .BAR_BASE (BAR_BASE)
    ) i_pci_target (
        .pci_clk_pad_i (pci_clk_pad_i),
        .pci_rst_pad_i (pci_rst_pad_i),
        .pci_i         (pci_i),
        .pci_o         (pci_o),
        .wbm_req_o     (pci_req),
        .wbm_rsp_i     (pci_rsp)
    );

    wb_test_master i_test_master (
        .pci_clk_pad_i (pci_clk_pad_i),
        .pci_rst_pad_i (pci_rst_pad_i),
        .start_i       (start_i),
        .host_cmd_i    (host_cmd_i),
        .done_o        (done_o),
        .rdata_o       (rdata_o),
        .wbm_req_o     (host_req),
        .wbm_rsp_i     (host_rsp)
    );

    // keeps the two masters off the sram at the same time
    wb_cyc_arbiter i_arbiter (
        .pci_clk_pad_i (pci_clk_pad_i),
        .pci_rst_pad_i (pci_rst_pad_i),
        .pci_req_i     (pci_req),
        .host_req_i    (host_req),
        .pci_rsp_o     (pci_rsp),
        .host_rsp_o    (host_rsp),
        .slv_req_o     (slv_req),
        .slv_rsp_i     (slv_rsp)
    );

    wb_sram_slave #(
        .MEM_WORDS (MEM_WORDS)
    ) i_sram (
        .pci_clk_pad_i (pci_clk_pad_i),
        .pci_rst_pad_i (pci_rst_pad_i),
        .wbs_req_i     (slv_req),
        .wbs_rsp_o     (slv_rsp)
    );

endmodule

`default_nettype wire

// ==== src/wb_cyc_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_cyc_arbiter
    import wb_pkg::*;
(
    input  wire          pci_clk_pad_i,
    input  wire          pci_rst_pad_i,
    input  wire wb_req_t pci_req_i,
    input  wire wb_req_t host_req_i,
    output wb_rsp_t      pci_rsp_o,
    output wb_rsp_t      host_rsp_o,
    output wb_req_t      slv_req_o,
    input  wire wb_rsp_t slv_rsp_i
);

    logic pci_gnt_q;
    logic host_gnt_q;

    always_ff @(posedge pci_clk_pad_i or negedge pci_rst_pad_i)
    begin
        if (!pci_rst_pad_i)
        begin
            pci_gnt_q  <= 1'b0;
            host_gnt_q <= 1'b0;
        end
        else
        begin
            if (!pci_gnt_q && !host_gnt_q)
            begin
                // pci side first when the slave is free
                if (pci_req_i.cyc)
                    pci_gnt_q <= 1'b1;
                else
                    host_gnt_q <= host_req_i.cyc;
            end
            else
            begin
                // hold until the owner drops cyc
                if (pci_gnt_q)
                    pci_gnt_q <= pci_req_i.cyc;
                if (host_gnt_q)
                    host_gnt_q <= host_req_i.cyc;
            end
        end
    end

    // loser keeps its request up and waits
    always_comb
    begin
        slv_req_o     = pci_gnt_q ? pci_req_i : host_req_i;
        slv_req_o.cyc = (pci_gnt_q && pci_req_i.cyc) || (host_gnt_q && host_req_i.cyc);
        slv_req_o.stb = (pci_gnt_q && pci_req_i.stb) || (host_gnt_q && host_req_i.stb);
    end

    always_comb
    begin
        pci_rsp_o.dat  = slv_rsp_i.dat;
        pci_rsp_o.ack  = slv_rsp_i.ack && pci_gnt_q;
        host_rsp_o.dat = slv_rsp_i.dat;
        host_rsp_o.ack = slv_rsp_i.ack && host_gnt_q;
    end

endmodule

`default_nettype wire

// ==== src/wb_sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_sram_slave
    import wb_pkg::*;
#(
    parameter int MEM_WORDS = 64
)
(
    input  wire          pci_clk_pad_i,
    input  wire          pci_rst_pad_i,
    input  wire wb_req_t wbs_req_i,
    output wb_rsp_t      wbs_rsp_o
);

    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [WB_DW-1:0] mem [MEM_WORDS];
    logic [AW-1:0]    idx;
    logic             access;
    logic             ack_q;
    logic [WB_DW-1:0] rdata_q;

    // word index wraps at the memory depth
    assign idx    = AW'(wbs_req_i.adr[31:2] % MEM_WORDS);
    assign access = wbs_req_i.cyc && wbs_req_i.stb && !ack_q;

    // no second ack while the master still holds stb
    always_ff @(posedge pci_clk_pad_i or negedge pci_rst_pad_i)
    begin
        if (!pci_rst_pad_i)
            ack_q <= 1'b0;
        else
            ack_q <= access;
    end

    always_ff @(posedge pci_clk_pad_i)
    begin
        if (access)
        begin
            if (wbs_req_i.we)
            begin
                for (int b = 0; b < WB_SW; b++)
                begin
                    if (wbs_req_i.sel[b])
                        mem[idx][8*b +: 8] <= wbs_req_i.dat[8*b +: 8];
                end
            end
            rdata_q <= mem[idx];
        end
    end

    assign wbs_rsp_o.ack = ack_q;
    assign wbs_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

// ==== src/wb_test_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_test_master
    import wb_pkg::*;
(
    input  wire              pci_clk_pad_i,
    input  wire              pci_rst_pad_i,
    input  wire              start_i,
    input  wire wb_req_t     host_cmd_i,
    output logic             done_o,
    output logic [WB_DW-1:0] rdata_o,
    output wb_req_t          wbm_req_o,
    input  wire wb_rsp_t     wbm_rsp_i
);

    logic    cyc_q;
    wb_req_t cmd_q;

    always_ff @(posedge pci_clk_pad_i or negedge pci_rst_pad_i)
    begin
        if (!pci_rst_pad_i)
        begin
            cyc_q  <= 1'b0;
            done_o <= 1'b0;
        end
        else
        begin
            done_o <= 1'b0;
            if (!cyc_q)
            begin
                if (start_i)
                    cyc_q <= 1'b1;
            end
            else if (wbm_rsp_i.ack)
            begin
                cyc_q  <= 1'b0;
                done_o <= 1'b1;
            end
        end
    end

    // command and read data
    always_ff @(posedge pci_clk_pad_i)
    begin
        if (!cyc_q && start_i)
            cmd_q <= host_cmd_i;
        if (cyc_q && wbm_rsp_i.ack)
            rdata_o <= wbm_rsp_i.dat;
    end

    // strobes come from the busy flag, not from the command
    always_comb
    begin
        wbm_req_o     = cmd_q;
        wbm_req_o.cyc = cyc_q;
        wbm_req_o.stb = cyc_q;
    end

endmodule

`default_nettype wire

// ==== verification/pci_test_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module pci_test_sva
    import pci_pkg::*;
(
    input wire             pci_clk_pad_i,
    input wire             pci_rst_pad_i,
    input wire             pci_gnt_i,
    input wire             host_gnt_i,
    input wire pci_in_t    bus_i,
    input wire pci_out_t   pins_i,
    input wire tgt_state_t state_i
);

    logic rd_cmd_q;

    // command of the last address phase, taken from the bus
    always_ff @(posedge pci_clk_pad_i)
    begin
        if (state_i == IDLE && !bus_i.frame_n)
            rd_cmd_q <= (bus_i.cbe_n == PCI_MEM_READ);
    end

    // one owner of the sram at a time
    grant_exclusive: assert property (@(posedge pci_clk_pad_i) disable iff (!pci_rst_pad_i)
        !(pci_gnt_i && host_gnt_i))
        else $error("both arbiter grants set");

    // trdy only driven while claimed, and only low with devsel low
    trdy_with_devsel: assert property (@(posedge pci_clk_pad_i) disable iff (!pci_rst_pad_i)
        pins_i.trdy_oe |-> (pins_i.devsel_oe && (pins_i.trdy_n || !pins_i.devsel_n)))
        else $error("trdy driven without devsel");

    // ad only driven in the trdy cycle of a read
    ad_oe_in_read_data: assert property (@(posedge pci_clk_pad_i) disable iff (!pci_rst_pad_i)
        pins_i.ad_oe |-> (rd_cmd_q && !pins_i.trdy_n))
        else $error("ad_oe outside a read trdy_n cycle");

endmodule

bind wb_cyc_arbiter pci_test_sva arbiter_sva (
    .pci_clk_pad_i (pci_clk_pad_i),
    .pci_rst_pad_i (pci_rst_pad_i),
    .pci_gnt_i     (pci_gnt_q),
    .host_gnt_i    (host_gnt_q),
    .bus_i         ('1),
    .pins_i        ('0),
    .state_i       (pci_pkg::IDLE)
);

bind pci_target_fsm pci_test_sva target_sva (
    .pci_clk_pad_i (pci_clk_pad_i),
    .pci_rst_pad_i (pci_rst_pad_i),
    .pci_gnt_i     (1'b0),
    .host_gnt_i    (1'b0),
    .bus_i         (pci_i),
    .pins_i        (pci_o),
    .state_i       (state_q)
);

`default_nettype wire

// ==== verification/pci_test_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pci_test_tb
    import wb_pkg::*, pci_pkg::*;
();

    localparam logic [15:0] BAR_BASE    = 16'h8000;
    localparam int          MEM_WORDS   = 64;
    localparam int          AW          = $clog2(MEM_WORDS);
    localparam int          NUM_TESTS   = 15;
    localparam int          CYCLE_LIMIT = NUM_TESTS * 40;

    typedef enum logic [2:0] {HOST_WR, HOST_RD, PCI_WR, PCI_RD, PCI_MISS, COLLIDE} test_kind_t;

    // cmd only matters for the miss rows
    typedef struct packed {
        test_kind_t  kind;
        logic        rnd;
        logic [3:0]  cmd;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } test_entry_t;

    logic             pci_clk_pad_i;
    logic             pci_rst_pad_i;
    pci_in_t          pci_in;
    pci_out_t         pci_out;
    logic             start_i;
    wb_req_t          host_cmd_i;
    logic             done_o;
    logic [WB_DW-1:0] rdata_o;

    test_entry_t tests [NUM_TESTS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] lcg_state = 32'h393b;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    pci_test_top #(
        .BAR_BASE  (BAR_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) DUT (
        .pci_clk_pad_i (pci_clk_pad_i),
        .pci_rst_pad_i (pci_rst_pad_i),
        .pci_i         (pci_in),
        .pci_o         (pci_out),
        .start_i       (start_i),
        .host_cmd_i    (host_cmd_i),
        .done_o        (done_o),
        .rdata_o       (rdata_o)
    );

    always #2 pci_clk_pad_i = ~pci_clk_pad_i;

    // 40 cycles per table entry is far above the slowest access
    always @(posedge pci_clk_pad_i)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [AW-1:0] word_index(input logic [31:0] adr);
        return AW'((adr >> 2) % MEM_WORDS);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] sel);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++)
        begin
            if (sel[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    task automatic model_write(input logic [31:0] adr, input logic [31:0] dat,
                               input logic [3:0] sel);
        logic [AW-1:0] idx;
        idx = word_index(adr);
        ref_mem[idx] = merge_bytes(ref_mem[idx], dat, sel);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp_val);
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp_val);
        err_cnt++;
    endtask

    task automatic record_result(input string label, input int errs_before);
        if (err_cnt == errs_before)
        begin
            $display("%s: pass", label);
            pass_cnt++;
        end
        else
        begin
            $display("%s: fail", label);
            fail_cnt++;
        end
    endtask

    task automatic load_table();
        // kind, random data, command, address, data, byte enables
        tests[0]  = '{HOST_WR,  1'b1, 4'h0, 32'h0000_0010, 32'h0, 4'hf};
        tests[1]  = '{HOST_RD,  1'b0, 4'h0, 32'h0000_0010, 32'h0, 4'hf};
        tests[2]  = '{HOST_WR,  1'b0, 4'h0, 32'h0000_0010, 32'h0000_a5c3, 4'h3};
        tests[3]  = '{HOST_RD,  1'b0, 4'h0, 32'h0000_0010, 32'h0, 4'hf};
        tests[4]  = '{PCI_WR,   1'b1, 4'h0, {BAR_BASE, 16'h0020}, 32'h0, 4'hf};
        tests[5]  = '{PCI_WR,   1'b0, 4'h0, {BAR_BASE, 16'h0020}, 32'h7e00_0000, 4'h8};
        tests[6]  = '{HOST_RD,  1'b0, 4'h0, 32'h0000_0020, 32'h0, 4'hf};
        tests[7]  = '{HOST_WR,  1'b1, 4'h0, 32'h0000_0030, 32'h0, 4'hf};
        tests[8]  = '{PCI_RD,   1'b0, 4'h0, {BAR_BASE, 16'h0030}, 32'h0, 4'hf};
        tests[9]  = '{PCI_RD,   1'b0, 4'h0, {BAR_BASE, 16'h0010}, 32'h0, 4'hf};
        tests[10] = '{PCI_MISS, 1'b1, 4'h7, 32'h4000_0010, 32'h0, 4'hf};
        tests[11] = '{PCI_MISS, 1'b1, 4'h3, {BAR_BASE, 16'h0010}, 32'h0, 4'hf};
        tests[12] = '{HOST_RD,  1'b0, 4'h0, 32'h0000_0010, 32'h0, 4'hf};
        tests[13] = '{COLLIDE,  1'b1, 4'h0, {BAR_BASE, 16'h0040}, 32'h0, 4'hf};
        tests[14] = '{HOST_RD,  1'b0, 4'h0, {BAR_BASE, 16'h0040}, 32'h0, 4'hf};
    endtask

    task automatic host_access(input logic we, input logic [31:0] adr,
                               input logic [31:0] wdat, input logic [3:0] sel,
                               output logic [31:0] rdat);
        int n;
        n = 0;
        @(posedge pci_clk_pad_i);
        #1;
        start_i    = 1'b1;
        host_cmd_i = '{cyc: 1'b0, stb: 1'b0, we: we, adr: adr, sel: sel, dat: wdat};
        @(posedge pci_clk_pad_i);
        #1;
        start_i = 1'b0;
        while (done_o !== 1'b1 && n < 20)
        begin
            @(negedge pci_clk_pad_i);
            n++;
        end
        rdat = rdata_o;
        if (done_o !== 1'b1)
        begin
            $display("host access to %h never finished, t=%0t", adr, $time);
            err_cnt++;
        end
    endtask

    // initiator side of one address phase and one data phase
    task automatic pci_access(input logic [3:0] cmd, input logic [31:0] adr,
                              input logic [31:0] wdat, input logic [3:0] sel,
                              input logic claim, output logic [31:0] rdat);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        rdat = '0;
        @(posedge pci_clk_pad_i);
        #1;
        pci_in.frame_n = 1'b0;
        pci_in.ad      = adr;
        pci_in.cbe_n   = cmd;
        @(negedge pci_clk_pad_i);
        if (pci_out.devsel_n !== 1'b1)
            report_mismatch("devsel_n", 32'(pci_out.devsel_n), 32'd1);
        @(posedge pci_clk_pad_i);
        #1;
        pci_in.frame_n = 1'b1;
        pci_in.irdy_n  = 1'b0;
        pci_in.ad      = wdat;
        pci_in.cbe_n   = ~sel;
        @(negedge pci_clk_pad_i);
        if (pci_out.devsel_n !== !claim)
            report_mismatch("devsel_n", 32'(pci_out.devsel_n), 32'(!claim));
        if (!claim)
        begin
            repeat (3)
            begin
                @(negedge pci_clk_pad_i);
                if (pci_out.devsel_n !== 1'b1)
                    report_mismatch("devsel_n", 32'(pci_out.devsel_n), 32'd1);
            end
        end
        else
        begin
            while (pci_out.trdy_n !== 1'b0 && n < 20)
            begin
                @(negedge pci_clk_pad_i);
                n++;
            end
            if (pci_out.trdy_n !== 1'b0)
            begin
                $display("target never asserted trdy_n for %h, t=%0t", adr, $time);
                err_cnt++;
            end
            else
            begin
                seen = 1'b1;
                rdat = pci_out.ad;
                if (pci_out.ad_oe !== (cmd == PCI_MEM_READ))
                    report_mismatch("ad_oe", 32'(pci_out.ad_oe), 32'(cmd == PCI_MEM_READ));
            end
        end
        @(posedge pci_clk_pad_i);
        #1;
        pci_in.irdy_n = 1'b1;
        if (seen)
        begin
            // turnaround keeps the strobes driven high once
            @(negedge pci_clk_pad_i);
            if ({pci_out.devsel_n, pci_out.trdy_n, pci_out.devsel_oe, pci_out.trdy_oe} !== 4'hf)
                report_mismatch("turnaround strobes",
                                32'({pci_out.devsel_n, pci_out.trdy_n,
                                     pci_out.devsel_oe, pci_out.trdy_oe}), 32'hf);
            @(negedge pci_clk_pad_i);
            if ({pci_out.devsel_oe, pci_out.trdy_oe, pci_out.ad_oe} !== 3'b000)
                report_mismatch("output enables",
                                32'({pci_out.devsel_oe, pci_out.trdy_oe, pci_out.ad_oe}), 32'd0);
        end
    endtask

    initial
    begin
        test_entry_t e;
        logic [31:0] wdat;
        logic [31:0] pdat;
        logic [31:0] rdat;
        logic [31:0] exp_dat;
        int          errs_before;

        pci_clk_pad_i = 1'b0;
        pci_rst_pad_i = 1'b0;
        pci_in        = '{frame_n: 1'b1, irdy_n: 1'b1, ad: 32'h0, cbe_n: 4'hf};
        start_i       = 1'b0;
        host_cmd_i    = '0;
        load_table();
        repeat (4) @(posedge pci_clk_pad_i);
        #1;
        pci_rst_pad_i = 1'b1;

        errs_before = err_cnt;
        @(negedge pci_clk_pad_i);
        if (done_o !== 1'b0)
            report_mismatch("done_o", 32'(done_o), 32'd0);
        if ({pci_out.devsel_oe, pci_out.trdy_oe, pci_out.ad_oe} !== 3'b000)
            report_mismatch("output enables",
                            32'({pci_out.devsel_oe, pci_out.trdy_oe, pci_out.ad_oe}), 32'd0);
        if ({pci_out.devsel_n, pci_out.trdy_n} !== 2'b11)
            report_mismatch("devsel_n/trdy_n", 32'({pci_out.devsel_n, pci_out.trdy_n}), 32'd3);
        record_result("reset values", errs_before);

        for (int i = 0; i < NUM_TESTS; i++)
        begin
            e           = tests[i];
            errs_before = err_cnt;
            wdat        = e.rnd ? lcg_next() : e.dat;
            case (e.kind)
                HOST_WR:
                begin
                    host_access(1'b1, e.adr, wdat, e.sel, rdat);
                    model_write(e.adr, wdat, e.sel);
                end
                HOST_RD:
                begin
                    host_access(1'b0, e.adr, 32'h0, 4'hf, rdat);
                    exp_dat = ref_mem[word_index(e.adr)];
                    if (rdat !== exp_dat)
                        report_mismatch("rdata_o", rdat, exp_dat);
                end
                PCI_WR:
                begin
                    pci_access(PCI_MEM_WRITE, e.adr, wdat, e.sel, 1'b1, rdat);
                    model_write(e.adr, wdat, e.sel);
                end
                PCI_RD:
                begin
                    pci_access(PCI_MEM_READ, e.adr, 32'h0, 4'hf, 1'b1, rdat);
                    exp_dat = ref_mem[word_index(e.adr)];
                    if (rdat !== exp_dat)
                        report_mismatch("pci_o.ad", rdat, exp_dat);
                end
                PCI_MISS:
                    pci_access(e.cmd, e.adr, wdat, e.sel, 1'b0, rdat);
                default:
                begin
                    // host start lands with the irdy phase so both cycs rise together
                    pdat = lcg_next();
                    fork
                        pci_access(PCI_MEM_WRITE, e.adr, pdat, e.sel, 1'b1, rdat);
                        begin
                            @(posedge pci_clk_pad_i);
                            host_access(1'b1, e.adr, wdat, e.sel, exp_dat);
                        end
                    join
                    model_write(e.adr, pdat, e.sel);
                    model_write(e.adr, wdat, e.sel);
                end
            endcase
            record_result($sformatf("test %0d %s", i, e.kind.name()), errs_before);
        end

        $display("%0d tests passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
